// ==== rtl/bank_ram.sv ====
`timescale 1ns/1ps

module bank_ram import mvu_dp_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  mvu_ext,
    input  logic                  wr_en,
    input  logic [DEPTH_LOG2-1:0] wr_addr,
    input  plane_t                wr_word,
    input  logic [DEPTH_LOG2-1:0] rd_addr,
    output plane_t                rd_word
);

    plane_t mem [2**DEPTH_LOG2];

    always_ff @(posedge mvu_ext) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_word <= mem[rd_addr];                    // Read-before-write on a clash
    end

endmodule

// ==== rtl/ctrl_delay.sv ====
`timescale 1ns/1ps

module ctrl_delay import mvu_dp_pkg::*; #(
    parameter int DEPTH = 1
) (
    input  logic       mvu_ext,
    input  logic       rst_n,
    input  pipe_ctrl_t in,
    output pipe_ctrl_t out
);

    pipe_ctrl_t stage [DEPTH];

    always_ff @(posedge mvu_ext) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;                 // No valid slots after reset
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[DEPTH-1];

endmodule

// ==== rtl/mvu_agu.sv ====
`timescale 1ns/1ps

module mvu_agu import mvu_cfg_pkg::*, mvu_dp_pkg::*; (
    input  logic       mvu_ext,
    input  logic       rst_n,
    input  logic       run,
    input  job_cfg_t   job,
    output daddr_t     rd_daddr,
    output waddr_t     rd_waddr,
    output pipe_ctrl_t ctrl
);

    // Loop counters count steps taken down from the MSB
    prec_t  icnt;
    prec_t  wcnt;
    waddr_t row_off;                                // Row index times wprec
    prec_t  ibit;
    prec_t  wbit;
    logic   ilast;
    logic   wlast;
    logic   d_msb;
    logic   w_msb;

    assign ibit  = job.iprec - 1'b1 - icnt;         // Bit index walks MSB down to 0
    assign wbit  = job.wprec - 1'b1 - wcnt;
    assign ilast = (ibit == '0);
    assign wlast = (wbit == '0);
    assign d_msb = (icnt == '0);
    assign w_msb = (wcnt == '0);

    assign rd_daddr = job.ibase + daddr_t'(ibit);
    assign rd_waddr = job.wbase + row_off + waddr_t'(wbit);

    // A signed MSB weighs negative and two of them cancel
    assign ctrl.valid = run;
    assign ctrl.neg   = (job.d_signed && d_msb) != (job.w_signed && w_msb);
    assign ctrl.ilast = run && ilast;
    assign ctrl.rlast = run && ilast && wlast;

    always_ff @(posedge mvu_ext) begin
        if (!rst_n || !run) begin
            icnt    <= '0;
            wcnt    <= '0;
            row_off <= '0;
        end else if (!ilast) begin
            icnt <= icnt + 1'b1;
        end else begin
            icnt <= '0;
            if (wlast) begin
                wcnt    <= '0;
                row_off <= row_off + waddr_t'(job.wprec);   // Next weight row
            end else begin
                wcnt <= wcnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mvu_cfg_pkg.sv ====
package mvu_cfg_pkg;

    localparam int MAX_PREC = 8;                    // Widest operand in bits

    typedef logic [7:0] daddr_t;                    // Input memory address
    typedef logic [8:0] waddr_t;                    // Weight memory address
    typedef logic [3:0] prec_t;                     // Operand precision, 1 to MAX_PREC
    typedef logic [5:0] nrows_t;                    // Matrix rows per job, 1 to 63

    // Longest job is every row at full precision on both operands
    localparam int JOB_CYC_MAX = (2**$bits(nrows_t) - 1) * MAX_PREC * MAX_PREC;

    typedef logic [$clog2(JOB_CYC_MAX + 1)-1:0] jobcnt_t;  // Job cycle countdown

    typedef struct packed {
        prec_t  iprec;                              // Input precision
        prec_t  wprec;                              // Weight precision
        nrows_t num_rows;                           // Dot products in this job
        daddr_t ibase;                              // First input bit-plane
        waddr_t wbase;                              // First weight bit-plane of row 0
        logic   d_signed;                           // Inputs are two's complement
        logic   w_signed;                           // Weights are two's complement
    } job_cfg_t;

endpackage

// ==== rtl/mvu_dp_pkg.sv ====
package mvu_dp_pkg;

    localparam int LANES = 8;                       // Vector length and bit-plane width

    // Latencies along the datapath
    localparam int MEM_RD_LATENCY = 1;
    localparam int VVP_STAGES     = 1;

    typedef logic [LANES-1:0] plane_t;              // One bit-plane of a vector

    // Popcount of LANES bits plus a sign bit
    typedef logic signed [$clog2(LANES + 1):0] term_t;

    typedef logic signed [23:0] acc_t;              // Accumulator and dot product

    typedef struct packed {
        logic valid;                                // Term in this slot is real
        logic neg;                                  // Subtract the term
        logic ilast;                                // Last input bit of a weight bit
        logic rlast;                                // Last term of a row
    } pipe_ctrl_t;

endpackage

// ==== rtl/mvu_job_ctrl.sv ====
`timescale 1ns/1ps

module mvu_job_ctrl import mvu_cfg_pkg::*; (
    input  logic     mvu_ext,
    input  logic     rst_n,
    input  logic     start,
    input  job_cfg_t cfg,
    output job_cfg_t job,
    output logic     run,
    output logic     done,
    output logic     irq
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t  state;
    jobcnt_t cnt;                                   // Run cycles left after this one
    jobcnt_t job_cycles;
    logic    accept;

    assign accept = start && (state == IDLE);       // Starts during a job are dropped
    assign run    = (state == RUN);

    // One cycle per input bit, per weight bit, per row
    assign job_cycles = jobcnt_t'(cfg.num_rows) * jobcnt_t'(cfg.iprec) * jobcnt_t'(cfg.wprec);

    always_ff @(posedge mvu_ext) begin
        if (accept) begin
            job <= cfg;
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            irq   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= RUN;
                        cnt   <= job_cycles - 1'b1;
                        irq   <= 1'b0;          // Previous job acknowledged by the new start
                    end
                end
                RUN: begin
                    if (cnt == '0) begin
                        state <= IDLE;
                        done  <= 1'b1;
                        irq   <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/mvu_top.sv ====
`timescale 1ns/1ps

module mvu_top import mvu_cfg_pkg::*, mvu_dp_pkg::*; (
    input  logic     mvu_ext,
    input  logic     rst_n,
    input  logic     start,
    input  job_cfg_t cfg,
    input  logic     wrd_en,
    input  daddr_t   wrd_addr,
    input  plane_t   wrd_word,
    input  logic     wrw_en,
    input  waddr_t   wrw_addr,
    input  plane_t   wrw_word,
    output logic     done,
    output logic     irq,
    output acc_t     result,
    output logic     result_valid
);

    job_cfg_t   job;
    logic       run;
    daddr_t     rd_daddr;
    waddr_t     rd_waddr;
    plane_t     dplane;
    plane_t     wplane;
    pipe_ctrl_t agu_ctrl;                           // Controls at address issue
    pipe_ctrl_t rd_ctrl;                            // Aligned with read data
    pipe_ctrl_t acc_ctrl;                           // Aligned with the term
    term_t      term;

    mvu_job_ctrl i_job_ctrl (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .start   (start),
        .cfg     (cfg),
        .job     (job),
        .run     (run),
        .done    (done),
        .irq     (irq)
    );

    mvu_agu i_agu (
        .mvu_ext  (mvu_ext),
        .rst_n    (rst_n),
        .run      (run),
        .job      (job),
        .rd_daddr (rd_daddr),
        .rd_waddr (rd_waddr),
        .ctrl     (agu_ctrl)
    );

    bank_ram #(
        .DEPTH_LOG2 ($bits(daddr_t))
    ) data_bank (
        .mvu_ext (mvu_ext),
        .wr_en   (wrd_en),
        .wr_addr (wrd_addr),
        .wr_word (wrd_word),
        .rd_addr (rd_daddr),
        .rd_word (dplane)
    );

    bank_ram #(
        .DEPTH_LOG2 ($bits(waddr_t))
    ) weight_bank (
        .mvu_ext (mvu_ext),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (rd_waddr),
        .rd_word (wplane)
    );

    ctrl_delay #(
        .DEPTH (MEM_RD_LATENCY)
    ) i_rd_delay (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .in      (agu_ctrl),
        .out     (rd_ctrl)
    );

    vvp_popcount i_vvp (
        .mvu_ext  (mvu_ext),
        .rst_n    (rst_n),
        .dplane   (dplane),
        .wplane   (wplane),
        .ctrl_in  (rd_ctrl),
        .term     (term),
        .ctrl_out (acc_ctrl)
    );

    shift_acc i_shift_acc (
        .mvu_ext      (mvu_ext),
        .rst_n        (rst_n),
        .term         (term),
        .ctrl         (acc_ctrl),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== rtl/shift_acc.sv ====
`timescale 1ns/1ps

module shift_acc import mvu_dp_pkg::*; (
    input  logic       mvu_ext,
    input  logic       rst_n,
    input  term_t      term,
    input  pipe_ctrl_t ctrl,
    output acc_t       result,
    output logic       result_valid
);

    acc_t inner_acc;                                // Horner sum over input bits
    acc_t outer_acc;                                // Horner sum over weight bits
    acc_t inner_next;
    acc_t outer_next;

    // Terms arrive MSB first, so each level doubles before it adds
    assign inner_next = (inner_acc <<< 1) + acc_t'(term);
    assign outer_next = (outer_acc <<< 1) + inner_next;

    always_ff @(posedge mvu_ext) begin
        if (!rst_n) begin
            inner_acc    <= '0;
            outer_acc    <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= ctrl.valid && ctrl.rlast;
            if (ctrl.valid) begin
                if (ctrl.ilast) begin
                    inner_acc <= '0;
                    outer_acc <= ctrl.rlast ? '0 : outer_next;  // Next row starts clean
                end else begin
                    inner_acc <= inner_next;
                end
            end
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (ctrl.valid && ctrl.rlast) begin
            result <= outer_next;
        end
    end

endmodule

// ==== rtl/vvp_popcount.sv ====
`timescale 1ns/1ps

module vvp_popcount import mvu_dp_pkg::*; (
    input  logic       mvu_ext,
    input  logic       rst_n,
    input  plane_t     dplane,
    input  plane_t     wplane,
    input  pipe_ctrl_t ctrl_in,
    output term_t      term,
    output pipe_ctrl_t ctrl_out
);

    logic [$clog2(LANES + 1)-1:0] ones;
    term_t                        term_d;
    term_t                        term_q [VVP_STAGES];

    always_comb begin
        ones = '0;
        for (int i = 0; i < LANES; i++) begin
            ones = ones + (dplane[i] & wplane[i]);  // 1x1 bit products
        end
    end

    assign term_d = ctrl_in.neg ? -term_t'({1'b0, ones}) : term_t'({1'b0, ones});

    always_ff @(posedge mvu_ext) begin
        term_q[0] <= term_d;
        for (int i = 1; i < VVP_STAGES; i++) begin
            term_q[i] <= term_q[i-1];
        end
    end

    assign term = term_q[VVP_STAGES-1];

    // Controls follow the term through the same number of stages
    ctrl_delay #(
        .DEPTH (VVP_STAGES)
    ) i_ctrl_delay (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .in      (ctrl_in),
        .out     (ctrl_out)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MVU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_mvu_top \
    -f sim.f \
    --Mdir obj_dir -o tb_mvu_top

./obj_dir/tb_mvu_top > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// ==== sim.f ====
rtl/mvu_cfg_pkg.sv
rtl/mvu_dp_pkg.sv
rtl/bank_ram.sv
rtl/ctrl_delay.sv
rtl/vvp_popcount.sv
rtl/shift_acc.sv
rtl/mvu_agu.sv
rtl/mvu_job_ctrl.sv
rtl/mvu_top.sv
testbench/tb_mvu_top.sv

// ==== testbench/tb_mvu_top.sv ====
`timescale 1ns/1ps

module tb_mvu_top import mvu_cfg_pkg::*, mvu_dp_pkg::*; ();

    localparam int N_RANDOM = 12;                   // Back-to-back random jobs
    localparam int MAX_RAND_ROWS = 10;

    logic     mvu_ext;
    logic     rst_n;
    logic     start;
    job_cfg_t cfg;
    logic     wrd_en;
    daddr_t   wrd_addr;
    plane_t   wrd_word;
    logic     wrw_en;
    waddr_t   wrw_addr;
    plane_t   wrw_word;
    logic     done;
    logic     irq;
    acc_t     result;
    logic     result_valid;

    int unsigned dvec [LANES];                      // Raw input elements
    int unsigned wmat [64][LANES];                  // Raw weight elements per row
    job_cfg_t    jobs [$];
    int          job_idx = 0;
    acc_t        results [$];                       // Every result seen since reset
    int          done_total = 0;
    int          errors = 0;
    int          checks = 0;
    int          budget_cycles = 0;

    mvu_top i_mvu_top (
        .mvu_ext      (mvu_ext),
        .rst_n        (rst_n),
        .start        (start),
        .cfg          (cfg),
        .wrd_en       (wrd_en),
        .wrd_addr     (wrd_addr),
        .wrd_word     (wrd_word),
        .wrw_en       (wrw_en),
        .wrw_addr     (wrw_addr),
        .wrw_word     (wrw_word),
        .done         (done),
        .irq          (irq),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #2 mvu_ext = ~mvu_ext;
    end

    // Outputs are stable at the falling edge
    always @(negedge mvu_ext) begin
        if (rst_n && result_valid) begin
            results.push_back(result);
        end
        if (rst_n && done) begin
            done_total++;
        end
    end

    initial begin
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge mvu_ext);
        $display("timeout: run still going after %0d cycles", budget_cycles);
        $display("tests failed");
        $finish;
    end

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int elem_value(input int unsigned raw, input int prec, input logic sgn);
        if (sgn && raw[prec-1]) begin
            return int'(raw) - (1 << prec);         // Two's complement MSB weighs negative
        end
        return int'(raw);
    endfunction

    function automatic acc_t expected_dot(input job_cfg_t c, input int r);
        int sum = 0;
        for (int i = 0; i < LANES; i++) begin
            sum += elem_value(dvec[i], int'(c.iprec), c.d_signed)
                 * elem_value(wmat[r][i], int'(c.wprec), c.w_signed);
        end
        return acc_t'(sum);
    endfunction

    function automatic int job_cycles(input job_cfg_t c);
        return int'(c.num_rows) * int'(c.iprec) * int'(c.wprec);
    endfunction

    function automatic job_cfg_t make_cfg(input int ip, input int wp, input int rows,
                                          input int ib, input int wb,
                                          input logic ds, input logic ws);
        job_cfg_t c;
        c.iprec    = prec_t'(ip);
        c.wprec    = prec_t'(wp);
        c.num_rows = nrows_t'(rows);
        c.ibase    = daddr_t'(ib);
        c.wbase    = waddr_t'(wb);
        c.d_signed = ds;
        c.w_signed = ws;
        return c;
    endfunction

    function automatic job_cfg_t random_cfg();
        int ip;
        int wp;
        int rows;
        ip   = int'($urandom_range(MAX_PREC, 1));
        wp   = int'($urandom_range(MAX_PREC, 1));
        rows = int'($urandom_range(MAX_RAND_ROWS, 1));
        return make_cfg(ip, wp, rows,
                        int'($urandom_range(2**$bits(daddr_t) - ip, 0)),
                        int'($urandom_range(2**$bits(waddr_t) - rows * wp, 0)),
                        logic'($urandom_range(1, 0)), logic'($urandom_range(1, 0)));
    endfunction

    function automatic plane_t data_plane(input int b);
        plane_t p;
        for (int i = 0; i < LANES; i++) begin
            p[i] = dvec[i][b];                      // Lane i takes bit b of element i
        end
        return p;
    endfunction

    function automatic plane_t weight_plane(input int r, input int b);
        plane_t p;
        for (int i = 0; i < LANES; i++) begin
            p[i] = wmat[r][i][b];
        end
        return p;
    endfunction

    task automatic write_word(input logic to_weights, input int addr, input plane_t word);
        @(posedge mvu_ext);
        wrd_en   <= !to_weights;
        wrd_addr <= daddr_t'(addr);
        wrd_word <= word;
        wrw_en   <= to_weights;
        wrw_addr <= waddr_t'(addr);
        wrw_word <= word;
    endtask

    // Takes the next job, fills it with random elements and writes the bit-planes
    task automatic prepare_job(output job_cfg_t c);
        c = jobs[job_idx];
        job_idx++;
        for (int i = 0; i < LANES; i++) begin
            dvec[i] = $urandom & ((32'd1 << c.iprec) - 1);
            for (int r = 0; r < int'(c.num_rows); r++) begin
                wmat[r][i] = $urandom & ((32'd1 << c.wprec) - 1);
            end
        end
        for (int b = 0; b < int'(c.iprec); b++) begin
            write_word(1'b0, int'(c.ibase) + b, data_plane(b));
        end
        for (int r = 0; r < int'(c.num_rows); r++) begin
            for (int b = 0; b < int'(c.wprec); b++) begin
                write_word(1'b1, int'(c.wbase) + r * int'(c.wprec) + b, weight_plane(r, b));
            end
        end
        @(posedge mvu_ext);
        wrd_en <= 1'b0;
        wrw_en <= 1'b0;
    endtask

    task automatic run_job(input job_cfg_t c, input logic extra_start);
        int res_base;
        int done_base;
        int rows;
        int limit;
        int cyc;
        res_base  = results.size();
        done_base = done_total;
        rows      = int'(c.num_rows);
        @(posedge mvu_ext);
        start <= 1'b1;
        cfg   <= c;
        @(posedge mvu_ext);
        start <= 1'b0;
        cfg   <= '0;
        @(negedge mvu_ext);
        check_bit("irq", irq, 1'b0);                // Cleared by the accepted start
        if (extra_start) begin
            @(posedge mvu_ext);
            start <= 1'b1;                          // Lands mid-job with another config
            cfg   <= random_cfg();
            @(posedge mvu_ext);
            start <= 1'b0;
            cfg   <= '0;
        end
        limit = job_cycles(c) + 8;
        for (cyc = 0; cyc < limit && done_total == done_base; cyc++) begin
            @(negedge mvu_ext);
        end
        if (done_total == done_base) begin
            $display("done never pulsed within %0d cycles of start", limit);
            errors++;
        end
        for (cyc = 0; cyc < 8 && results.size() - res_base < rows; cyc++) begin
            @(negedge mvu_ext);
        end
        repeat (4) @(negedge mvu_ext);              // Room for stray results or pulses
        if (results.size() - res_base != rows) begin
            $display("job expected %0d results but saw %0d", rows, results.size() - res_base);
            errors++;
        end
        if (done_total - done_base > 1) begin
            $display("done pulsed %0d times in one job", done_total - done_base);
            errors++;
        end
        check_bit("irq", irq, 1'b1);
        for (int r = 0; r < rows && res_base + r < results.size(); r++) begin
            check_acc($sformatf("result[%0d]", r), results[res_base + r], expected_dot(c, r));
        end
    endtask

    task automatic test_reset();
        job_cfg_t c;
        @(negedge mvu_ext);
        check_bit("done", done, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        prepare_job(c);                             // 1x1 bit job is a plain popcount
        run_job(c, 1'b0);
    endtask

    task automatic test_unsigned();
        job_cfg_t c;
        prepare_job(c);
        run_job(c, 1'b0);
    endtask

    task automatic test_signed();
        job_cfg_t c;
        repeat (3) begin
            prepare_job(c);
            run_job(c, 1'b0);
        end
    endtask

    task automatic test_job_control();
        job_cfg_t c;
        prepare_job(c);
        run_job(c, 1'b1);
        repeat (5) begin
            @(negedge mvu_ext);
            check_bit("irq", irq, 1'b1);            // Held until the next start
            check_bit("done", done, 1'b0);
        end
        prepare_job(c);
        run_job(c, 1'b0);
    endtask

    task automatic test_random();
        job_cfg_t c;
        repeat (N_RANDOM) begin
            prepare_job(c);
            run_job(c, 1'b0);
        end
    endtask

    initial begin
        int cost;
        void'($urandom(32'hab80_841d));
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        wrd_en   = 1'b0;
        wrd_addr = '0;
        wrd_word = '0;
        wrw_en   = 1'b0;
        wrw_addr = '0;
        wrw_word = '0;
        jobs.push_back(make_cfg(1, 1, 4, 0, 0, 1'b0, 1'b0));
        jobs.push_back(make_cfg(3, 5, 6, 8, 16, 1'b0, 1'b0));
        jobs.push_back(make_cfg(4, 3, 5, 20, 64, 1'b1, 1'b0));
        jobs.push_back(make_cfg(2, 6, 4, 24, 128, 1'b0, 1'b1));
        jobs.push_back(make_cfg(8, 8, 3, 32, 200, 1'b1, 1'b1));
        jobs.push_back(make_cfg(3, 2, 5, 40, 300, 1'b1, 1'b1));
        jobs.push_back(make_cfg(5, 4, 3, 60, 320, 1'b0, 1'b1));
        repeat (N_RANDOM) jobs.push_back(random_cfg());
        cost = 0;
        foreach (jobs[n]) begin
            // Run cycles plus memory loading plus fixed overhead
            cost += job_cycles(jobs[n]) + int'(jobs[n].iprec)
                  + int'(jobs[n].num_rows) * int'(jobs[n].wprec) + 16;
        end
        budget_cycles = 2 * cost + 200;
        repeat (2) @(posedge mvu_ext);
        rst_n <= 1'b1;
        test_reset();
        test_unsigned();
        test_signed();
        test_job_control();
        test_random();
        repeat (4) @(posedge mvu_ext);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
